/* Bender.yml */
package:
  name: udp_tx

sources:
  - udp_tx_pkg.sv
  - crc32_d4.sv
  - payload_fifo.sv
  - udp_header_gen.sv
  - mii_frame_tx.sv
  - udp_tx_top.sv
  - target: test
    files:
      - udp_tx_checker.sv
      - tb_udp_tx.sv

/* compile.f */
udp_tx_pkg.sv
crc32_d4.sv
payload_fifo.sv
udp_header_gen.sv
mii_frame_tx.sv
udp_tx_top.sv
udp_tx_checker.sv
tb_udp_tx.sv

/* crc32_d4.sv */
`timescale 1ns/10ps
`default_nettype none

module crc32_d4
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       clear,
    input  wire                       enable,
    input  wire udp_tx_pkg::nibble_t  din,
    output udp_tx_pkg::word_t         crc
);
    import udp_tx_pkg::*;

    word_t crc_next;

    // shift four bits in, din[0] first
    always_comb
    begin
        crc_next = crc;
        for (int i = 0; i < 4; i++)
        begin
            if (crc_next[0] ^ din[i])
                crc_next = (crc_next >> 1) ^ CRC_POLY;
            else
                crc_next = crc_next >> 1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            crc <= CRC_INIT;
        else if (clear)
            crc <= CRC_INIT;
        else if (enable)
            crc <= crc_next;
    end

endmodule

`default_nettype wire

/* mii_frame_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module mii_frame_tx
(
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire udp_tx_pkg::frame_hdr_t  hdr,
    input  wire udp_tx_pkg::len_t        payload_len,
    input  wire                          hdr_valid,
    input  wire udp_tx_pkg::word_t       rd_data,
    output logic                         rd_en,
    output logic                         tx_busy,
    output logic                         eth_tx_en,
    output udp_tx_pkg::nibble_t          eth_tx_data,
    output logic                         send_end
);
    import udp_tx_pkg::*;

    localparam int FCS_BYTES = 4;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_PREAMBLE,
        PH_HEADER,
        PH_PAYLOAD,
        PH_PAD,
        PH_FCS,
        PH_DONE
    } phase_t;

    phase_t     phase;
    phase_t     cur;        // phase of the nibble loaded at the coming edge
    logic       nib_hi;     // 0 = low nibble of the byte
    len_t       byte_cnt;
    len_t       last_byte;
    logic       byte_done;
    logic [7:0] cur_byte;
    nibble_t    cur_nib;
    logic       crc_en;
    word_t      crc;

    // start on the first preamble nibble straight from idle
    assign cur = (phase == PH_IDLE && hdr_valid) ? PH_PREAMBLE : phase;

    always_comb
    begin
        case (cur)
            PH_PREAMBLE: last_byte = len_t'(PREAMBLE_BYTES - 1);
            PH_HEADER:   last_byte = len_t'(HDR_BYTES - 1);
            PH_PAYLOAD:  last_byte = payload_len - 16'd1;
            PH_PAD:      last_byte = len_t'(MIN_PAYLOAD - 1);  // pad counts on from payload
            default:     last_byte = len_t'(FCS_BYTES - 1);
        endcase
    end

    assign byte_done = nib_hi && (byte_cnt == last_byte);

    always_comb
    begin
        case (cur)
            PH_PREAMBLE:
                cur_byte = (byte_cnt == len_t'(PREAMBLE_BYTES - 1)) ? SFD_BYTE : PREAMBLE_BYTE;
            PH_HEADER:
                cur_byte = hdr[(HDR_BYTES - 1 - int'(byte_cnt)) * 8 +: 8];
            PH_PAYLOAD:
                cur_byte = rd_data[(3 - int'(byte_cnt[1:0])) * 8 +: 8];  // msb byte first
            PH_FCS:
                cur_byte = ~crc[int'(byte_cnt[1:0]) * 8 +: 8];
            default:
                cur_byte = 8'h00;   // pad
        endcase
    end

    assign cur_nib = nib_hi ? cur_byte[7:4] : cur_byte[3:0];

    // pop after the last nibble of a word or of the payload
    assign rd_en   = (cur == PH_PAYLOAD) && nib_hi && (byte_cnt[1:0] == 2'd3 || byte_done);
    assign crc_en  = (cur == PH_HEADER) || (cur == PH_PAYLOAD) || (cur == PH_PAD);
    assign tx_busy = (phase != PH_IDLE) || send_end;

    crc32_d4 u_crc
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (hdr_valid),
        .enable (crc_en),
        .din    (cur_nib),
        .crc    (crc)
    );

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase       <= PH_IDLE;
            nib_hi      <= 1'b0;
            byte_cnt    <= '0;
            eth_tx_en   <= 1'b0;
            eth_tx_data <= '0;
            send_end    <= 1'b0;
        end
        else
        begin
            send_end    <= (cur == PH_DONE);
            eth_tx_en   <= 1'b0;
            eth_tx_data <= '0;
            case (cur)
                PH_IDLE: ;
                PH_DONE: phase <= PH_IDLE;
                default:
                begin
                    eth_tx_en   <= 1'b1;
                    eth_tx_data <= cur_nib;
                    nib_hi      <= ~nib_hi;
                    phase       <= cur;
                    if (byte_done)
                    begin
                        byte_cnt <= '0;
                        case (cur)
                            PH_PREAMBLE: phase <= PH_HEADER;
                            PH_HEADER:
                                phase <= (payload_len == '0) ? PH_PAD : PH_PAYLOAD;
                            PH_PAYLOAD:
                            begin
                                if (payload_len < len_t'(MIN_PAYLOAD))
                                begin
                                    phase    <= PH_PAD;
                                    byte_cnt <= payload_len;
                                end
                                else
                                    phase <= PH_FCS;
                            end
                            PH_PAD:  phase <= PH_FCS;
                            default: phase <= PH_DONE;
                        endcase
                    end
                    else if (nib_hi)
                        byte_cnt <= byte_cnt + 16'd1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* payload_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module payload_fifo
#(
    parameter int DEPTH = 32
)
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     wr_en,
    input  wire udp_tx_pkg::word_t  wr_data,
    input  wire                     rd_en,
    output udp_tx_pkg::word_t       rd_data,
    output logic                    full
);
    import udp_tx_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;

    assign do_wr   = wr_en && !full;    // writes while full are lost
    assign full    = (count == (AW+1)'(DEPTH));
    assign rd_data = mem[rd_ptr];        // head word, no read latency

    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb_udp_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_udp_tx;
    import udp_tx_pkg::*;

    localparam mac_t     BOARD_MAC  = 48'h02_12_34_56_78_9a;
    localparam ip_addr_t BOARD_IP   = 32'h0a_00_00_02;
    localparam port_t    BOARD_PORT = 16'd5000;
    localparam mac_t     PC_MAC     = 48'h02_00_00_00_00_63;
    localparam ip_addr_t PC_IP      = 32'h0a_00_00_63;
    localparam port_t    PC_PORT    = 16'd6001;
    localparam int       DEPTH      = 32;
    localparam int       N_FRAMES   = 9;

    logic        clk;
    logic        rst_n;
    logic        send_en;
    len_t        send_data_num;
    logic        wr_en;
    word_t       wr_data;
    logic        fifo_full;
    logic        send_end;
    logic        eth_tx_en;
    nibble_t     eth_tx_data;
    int          frames_seen;
    int          chk_errors;
    int          tb_errors;
    int          last_errs;
    int          n_tests;
    int          n_failed;
    int          frames_sent;
    logic [31:0] lcg;
    logic [15:0] exp_id;
    word_t       model_q [$];  // words the FIFO should hold
    int          frame_ns [N_FRAMES] = '{10, 20, 30, 5, 64, 23, 8, 12, 128};

    udp_tx_top
    #(
        .BOARD_MAC  (BOARD_MAC),
        .BOARD_IP   (BOARD_IP),
        .BOARD_PORT (BOARD_PORT),
        .PC_MAC     (PC_MAC),
        .PC_IP      (PC_IP),
        .PC_PORT    (PC_PORT),
        .FIFO_DEPTH (DEPTH)
    )
    uut
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .send_en       (send_en),
        .send_data_num (send_data_num),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .fifo_full     (fifo_full),
        .send_end      (send_end),
        .eth_tx_en     (eth_tx_en),
        .eth_tx_data   (eth_tx_data)
    );

    udp_tx_checker u_chk
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .eth_tx_en   (eth_tx_en),
        .eth_tx_data (eth_tx_data),
        .send_end    (send_end),
        .frames_seen (frames_seen),
        .errors      (chk_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ones' complement of the ones' complement sum of ten words
    function automatic logic [15:0] ip_checksum(input logic [159:0] iph);
        logic [31:0] sum;
        sum = 32'd0;
        for (int i = 0; i < 10; i++)
            sum = sum + iph[i*16 +: 16];
        while (sum[31:16] != 16'd0)
            sum = sum[31:16] + sum[15:0];
        return ~sum[15:0];
    endfunction

    task automatic expect_frame(input string name, input int n);
        logic [7:0]   b [$];
        nibble_t      nib [$];
        logic [159:0] iph;
        logic [335:0] h;
        logic [31:0]  crc;
        logic [31:0]  fcs;
        word_t        w;
        int           body;
        exp_id = exp_id + 16'd1;
        iph = {8'h45, 8'h00, 16'(n + 28), exp_id, 16'h4000, 8'h40, 8'd17, 16'h0000,
               BOARD_IP, PC_IP};
        h = {PC_MAC, BOARD_MAC, 16'h0800, iph[159:80], ip_checksum(iph), iph[63:0],
             BOARD_PORT, PC_PORT, 16'(n + 8), 16'h0000};
        for (int i = 0; i < 7; i++)
            b.push_back(8'h55);
        b.push_back(8'hD5);
        for (int i = 0; i < 42; i++)
            b.push_back(h[335 - 8*i -: 8]);
        body = (n < 18) ? 18 : n;
        w = '0;
        for (int i = 0; i < body; i++)
        begin
            if (i % 4 == 0 && i < n)
                w = model_q.pop_front();   // a partial last word is still popped
            b.push_back((i < n) ? w[31 - 8*(i % 4) -: 8] : 8'h00);
        end
        foreach (b[i])
        begin
            nib.push_back(b[i][3:0]);
            nib.push_back(b[i][7:4]);
        end
        crc = CRC_INIT;
        for (int i = 16; i < nib.size(); i++)
        begin
            for (int k = 0; k < 4; k++)
                crc = (crc[0] ^ nib[i][k]) ? ((crc >> 1) ^ CRC_POLY) : (crc >> 1);
        end
        fcs = ~crc;
        for (int k = 0; k < 8; k++)
            nib.push_back(fcs[4*k +: 4]);
        foreach (nib[i])
            u_chk.push_nibble(nib[i]);
        u_chk.push_frame(name, nib.size());
    endtask

    task automatic write_words(input int count);
        for (int i = 0; i < count; i++)
        begin
            lcg = lcg_next(lcg);
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_data <= lcg;
            if (model_q.size() < DEPTH)
                model_q.push_back(lcg);
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic run_frame(input string name, input int n, input logic hold);
        expect_frame(name, n);
        frames_sent++;
        @(posedge clk);
        send_en       <= 1'b1;
        send_data_num <= len_t'(n);
        @(posedge clk);
        if (!hold)
            send_en <= 1'b0;
    endtask

    task automatic wait_frames();
        wait (frames_seen == frames_sent);
    endtask

    task automatic compare_flag(input string name, input logic want, input logic got);
        if (got !== want)
        begin
            $display("Mismatch in %s: fifo_full expected %b, actual %b", name, want, got);
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = tb_errors + chk_errors;
        n_tests++;
        if (errs != last_errs)
        begin
            n_failed++;
            $display("test %s: failed with %0d errors", name, errs - last_errs);
        end
        else
            $display("test %s: ok", name);
        last_errs = errs;
    endtask

    initial
    begin
        logic extra;
        rst_n = 1'b0;
        send_en = 1'b0;
        send_data_num = '0;
        wr_en = 1'b0;
        wr_data = '0;
        lcg = 32'h5826_04a9;
        exp_id = 16'd0;
        tb_errors = 0;
        last_errs = 0;
        n_tests = 0;
        n_failed = 0;
        frames_sent = 0;
        extra = 1'b0;
        repeat (7) @(posedge clk);
        @(negedge clk);
        if (send_end !== 1'b0 || eth_tx_en !== 1'b0
            || eth_tx_data !== 4'h0 || fifo_full !== 1'b0)
        begin
            $display("outputs are not all zero during reset");
            tb_errors++;
        end
        @(posedge clk);
        rst_n <= 1'b1;
        end_test("reset_values");

        write_words(16);    // three payloads of 3 + 5 + 8 words
        run_frame("csum_id", 10, 1'b0);
        wait_frames();
        run_frame("csum_id", 20, 1'b0);
        wait_frames();
        run_frame("csum_id", 30, 1'b0);
        wait_frames();
        end_test("csum_id");

        write_words(2);
        run_frame("short_pad", 5, 1'b0);
        wait_frames();
        end_test("short_pad");

        write_words(16);
        run_frame("long_payload", 64, 1'b0);
        wait_frames();
        end_test("long_payload");

        write_words(8);
        run_frame("odd_count", 23, 1'b0);
        wait_frames();
        run_frame("odd_count", 8, 1'b0);
        wait_frames();
        end_test("odd_count");

        // send_en held high plus a second edge mid-frame
        write_words(3);
        run_frame("start_busy", 12, 1'b1);
        wait (eth_tx_en);
        repeat (40) @(posedge clk);
        send_en <= 1'b0;
        @(posedge clk);
        send_en <= 1'b1;
        wait_frames();
        for (int i = 0; i < 16; i++)
        begin
            @(negedge clk);
            if (eth_tx_en)
                extra = 1'b1;
        end
        if (extra || frames_seen != frames_sent)
        begin
            $display("a start edge while busy produced an extra frame");
            tb_errors++;
        end
        @(posedge clk);
        send_en <= 1'b0;
        end_test("start_busy");

        write_words(DEPTH);
        @(negedge clk);
        compare_flag("full_fifo", 1'b1, fifo_full);
        write_words(1);     // dropped while the FIFO is full
        @(negedge clk);
        compare_flag("full_fifo", 1'b1, fifo_full);
        run_frame("full_fifo", 4 * DEPTH, 1'b0);
        wait_frames();
        end_test("full_fifo");

        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed,
                 tb_errors + chk_errors);
        if (n_failed == 0 && tb_errors + chk_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // twice the frame lengths plus 20 spare cycles per frame
    initial
    begin
        int limit;
        int cycles;
        limit = 0;
        cycles = 0;
        foreach (frame_ns[i])
            limit += 2 * (8 + 42 + ((frame_ns[i] < 18) ? 18 : frame_ns[i]) + 4) + 20;
        limit = limit * 2;
        while (cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d cycles", limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* udp_header_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_header_gen
#(
    parameter udp_tx_pkg::mac_t     BOARD_MAC  = 48'h00_0a_35_01_fe_c0,
    parameter udp_tx_pkg::ip_addr_t BOARD_IP   = 32'hc0_a8_00_0a,
    parameter udp_tx_pkg::port_t    BOARD_PORT = 16'd1234,
    parameter udp_tx_pkg::mac_t     PC_MAC     = 48'hff_ff_ff_ff_ff_ff,
    parameter udp_tx_pkg::ip_addr_t PC_IP      = 32'hc0_a8_00_64,
    parameter udp_tx_pkg::port_t    PC_PORT    = 16'd1234
)
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         send_en,
    input  wire udp_tx_pkg::len_t       send_data_num,
    input  wire                         tx_busy,
    output udp_tx_pkg::frame_hdr_t      hdr,
    output udp_tx_pkg::len_t            payload_len,
    output logic                        hdr_valid
);
    import udp_tx_pkg::*;

    logic        send_en_q;
    logic        start;
    logic        hdr_load;      // one cycle after the accepted edge
    logic        csum_run;
    logic [1:0]  csum_step;
    logic [31:0] ip_sum;
    logic [31:0] csum_acc;

    // edges are ignored while a header is in flight or the MII side is busy
    assign start = send_en && !send_en_q && !tx_busy && !hdr_load && !csum_run && !hdr_valid;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            send_en_q <= 1'b0;
        else
            send_en_q <= send_en;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hdr_load    <= 1'b0;
            csum_run    <= 1'b0;
            csum_step   <= 2'd0;
            hdr_valid   <= 1'b0;
            payload_len <= '0;
        end
        else
        begin
            hdr_valid <= 1'b0;
            hdr_load  <= start;
            if (start)
                payload_len <= send_data_num;
            if (hdr_load)
            begin
                csum_run  <= 1'b1;
                csum_step <= 2'd0;
            end
            else if (csum_run)
            begin
                csum_step <= csum_step + 2'd1;
                if (csum_step == 2'd3)
                begin
                    csum_run  <= 1'b0;
                    hdr_valid <= 1'b1;  // goes out with the checksum write
                end
            end
        end
    end

    // ten header words, checksum field still zero here
    assign ip_sum = {hdr.ver_ihl, hdr.tos} + hdr.ip_len + hdr.ip_id + hdr.flags_frag
                  + {hdr.ttl, hdr.proto} + hdr.ip_csum
                  + hdr.src_ip[31:16] + hdr.src_ip[15:0]
                  + hdr.dst_ip[31:16] + hdr.dst_ip[15:0];

    always_ff @(posedge clk)
    begin
        if (csum_run)
        begin
            if (csum_step == 2'd0)
                csum_acc <= ip_sum;
            else
                csum_acc <= csum_acc[31:16] + csum_acc[15:0];   // end-around carry
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            hdr <= '0;
        else if (hdr_load)
        begin
            hdr.dst_mac    <= PC_MAC;
            hdr.src_mac    <= BOARD_MAC;
            hdr.eth_type   <= ETH_TYPE_IPV4;
            hdr.ver_ihl    <= IP_VER_IHL;
            hdr.tos        <= 8'h00;
            hdr.ip_len     <= payload_len + len_t'(IP_HDR_BYTES + UDP_HDR_BYTES);
            hdr.ip_id      <= hdr.ip_id + 16'd1;   // first frame carries 1
            hdr.flags_frag <= IP_FLAGS_DF;
            hdr.ttl        <= IP_TTL;
            hdr.proto      <= IP_PROTO_UDP;
            hdr.ip_csum    <= 16'h0000;
            hdr.src_ip     <= BOARD_IP;
            hdr.dst_ip     <= PC_IP;
            hdr.src_port   <= BOARD_PORT;
            hdr.dst_port   <= PC_PORT;
            hdr.udp_len    <= payload_len + len_t'(UDP_HDR_BYTES);
            hdr.udp_csum   <= 16'h0000;    // udp checksum unused
        end
        else if (csum_run && csum_step == 2'd3)
            hdr.ip_csum <= ~csum_acc[15:0];
    end

endmodule

`default_nettype wire

/* udp_tx_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_tx_checker
(
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      eth_tx_en,
    input  wire udp_tx_pkg::nibble_t eth_tx_data,
    input  wire                      send_end,
    output int                       frames_seen,
    output int                       errors
);
    import udp_tx_pkg::*;

    nibble_t exp_nib [$];   // all expected frames back to back
    int      exp_len [$];
    string   exp_name [$];
    nibble_t got [$];
    logic    en_q;          // eth_tx_en one sample back

    task automatic push_nibble(input nibble_t nib);
        exp_nib.push_back(nib);
    endtask

    task automatic push_frame(input string name, input int len);
        exp_name.push_back(name);
        exp_len.push_back(len);
    endtask

    task automatic compare_frame();
        string   name;
        int      len;
        nibble_t want;
        frames_seen++;
        if (exp_len.size() == 0)
        begin
            $display("unexpected frame of %0d nibbles on the MII, none was queued", got.size());
            errors++;
        end
        else
        begin
            name = exp_name.pop_front();
            len  = exp_len.pop_front();
            if (got.size() != len)
            begin
                $display("Mismatch in %s: frame length expected %0d nibbles, actual %0d",
                         name, len, got.size());
                errors++;
            end
            for (int i = 0; i < len; i++)
            begin
                want = exp_nib.pop_front();
                if (i < got.size() && got[i] !== want)
                begin
                    errors++;
                    $display("Mismatch in %s: nibble %0d expected %h, actual %h",
                             name, i, want, got[i]);
                end
            end
        end
        got.delete();
    endtask

    // sampled mid-cycle where outputs have settled
    always @(negedge clk)
    begin
        if (!rst_n)
            got.delete();
        else
        begin
            if (eth_tx_en)
                got.push_back(eth_tx_data);
            if (send_end !== (en_q && !eth_tx_en))
            begin
                $display("send_end did not pulse once in the cycle after the last nibble");
                errors++;
            end
            if (send_end)
                compare_frame();
        end
        en_q = eth_tx_en;
    end

endmodule

`default_nettype wire

/* udp_tx_pkg.sv */
`default_nettype none

package udp_tx_pkg;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [15:0] len_t;

    // ethernet framing
    localparam logic [15:0] ETH_TYPE_IPV4  = 16'h0800;
    localparam logic [7:0]  PREAMBLE_BYTE  = 8'h55;
    localparam logic [7:0]  SFD_BYTE       = 8'hD5;
    localparam int          PREAMBLE_BYTES = 8;     // seven 0x55 plus the SFD
    localparam int          MIN_PAYLOAD    = 18;    // 46 byte minimum minus IP and UDP headers

    localparam int          IP_HDR_BYTES   = 20;
    localparam int          UDP_HDR_BYTES  = 8;
    localparam int          HDR_BYTES      = 42;    // mac + ip + udp

    // fixed IPv4 fields
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    localparam logic [7:0]  IP_TTL         = 8'h40;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [15:0] IP_FLAGS_DF    = 16'h4000;

    // reflected form, shifted right
    localparam logic [31:0] CRC_POLY       = 32'hEDB8_8320;
    localparam logic [31:0] CRC_INIT       = 32'hFFFF_FFFF;

    // first byte on the wire sits at the top
    typedef struct packed {
        mac_t        dst_mac;
        mac_t        src_mac;
        logic [15:0] eth_type;
        logic [7:0]  ver_ihl;
        logic [7:0]  tos;
        len_t        ip_len;
        logic [15:0] ip_id;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  proto;
        logic [15:0] ip_csum;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        port_t       src_port;
        port_t       dst_port;
        len_t        udp_len;
        logic [15:0] udp_csum;
    } frame_hdr_t;

endpackage

`default_nettype wire

/* udp_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_tx_top
#(
    parameter udp_tx_pkg::mac_t     BOARD_MAC  = 48'h00_0a_35_01_fe_c0,
    parameter udp_tx_pkg::ip_addr_t BOARD_IP   = 32'hc0_a8_00_0a,
    parameter udp_tx_pkg::port_t    BOARD_PORT = 16'd1234,
    parameter udp_tx_pkg::mac_t     PC_MAC     = 48'hff_ff_ff_ff_ff_ff,
    parameter udp_tx_pkg::ip_addr_t PC_IP      = 32'hc0_a8_00_64,
    parameter udp_tx_pkg::port_t    PC_PORT    = 16'd1234,
    parameter int                   FIFO_DEPTH = 32
)
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     send_en,
    input  wire udp_tx_pkg::len_t   send_data_num,
    input  wire                     wr_en,
    input  wire udp_tx_pkg::word_t  wr_data,
    output logic                    fifo_full,
    output logic                    send_end,
    output logic                    eth_tx_en,
    output udp_tx_pkg::nibble_t     eth_tx_data
);
    import udp_tx_pkg::*;

    frame_hdr_t hdr;
    len_t       payload_len;
    logic       hdr_valid;
    logic       tx_busy;
    word_t      rd_data;
    logic       rd_en;

    udp_header_gen
    #(
        .BOARD_MAC  (BOARD_MAC),
        .BOARD_IP   (BOARD_IP),
        .BOARD_PORT (BOARD_PORT),
        .PC_MAC     (PC_MAC),
        .PC_IP      (PC_IP),
        .PC_PORT    (PC_PORT)
    )
    u_hdr_gen
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .send_en       (send_en),
        .send_data_num (send_data_num),
        .tx_busy       (tx_busy),
        .hdr           (hdr),
        .payload_len   (payload_len),
        .hdr_valid     (hdr_valid)
    );

    payload_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .full    (fifo_full)
    );

    mii_frame_tx u_mii_tx
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .hdr         (hdr),
        .payload_len (payload_len),
        .hdr_valid   (hdr_valid),
        .rd_data     (rd_data),
        .rd_en       (rd_en),
        .tx_busy     (tx_busy),
        .eth_tx_en   (eth_tx_en),
        .eth_tx_data (eth_tx_data),
        .send_end    (send_end)
    );

endmodule

`default_nettype wire
